/* rtl/nand_cpu_pkg.sv */
package nand_cpu_pkg;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_READ,
        REQ_WRITE
    } cache_request_t;

    // The instruction cache only ever uses READY, REQUEST_READ and READING
    typedef enum logic [2:0] {
        READY,
        REQUEST_WRITE,
        WRITING,
        REQUEST_READ,
        READING
    } cache_state_t;

    // ----------------------------------------
    // Block geometry
    // ----------------------------------------
    localparam int DATA_SIZE        = 16;
    localparam int CACHE_BLOCK_SIZE = 64;
    localparam int MEM_TRANS_SIZE   = 16;
    localparam int BEATS            = CACHE_BLOCK_SIZE / MEM_TRANS_SIZE;
    localparam int OFFSET_BITS      = $clog2(CACHE_BLOCK_SIZE / DATA_SIZE);

    // Addresses are 16-bit word addresses
    localparam int BLOCK_ADDR_BITS  = 16 - OFFSET_BITS;

endpackage

/* rtl/d_cache.sv */
`timescale 1ns/1ps

module d_cache #(
    parameter int INDEX_BITS = 6
) (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  logic                                       valid,
    input  logic                                       mem_access,
    input  logic [15:0]                                address,
    input  nand_cpu_pkg::mem_op_t                      mem_op,
    input  logic [15:0]                                data,
    output logic                                       hit,
    output logic                                       miss,
    output logic [15:0]                                rdata,
    output nand_cpu_pkg::cache_request_t               req,
    output logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   block_address,
    output logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    w_data,
    input  logic                                       ack,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    r_data
);

    localparam int LINES       = 2 ** INDEX_BITS;
    localparam int OFFSET_BITS = nand_cpu_pkg::OFFSET_BITS;
    localparam int TAG_BITS    = 16 - INDEX_BITS - OFFSET_BITS;
    localparam int CNT_BITS    = $clog2(nand_cpu_pkg::BEATS);
    localparam int WORD        = nand_cpu_pkg::DATA_SIZE;
    localparam int TRANS       = nand_cpu_pkg::MEM_TRANS_SIZE;

    logic [OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]    tag;

    logic [LINES-1:0]                            line_valid;
    logic [LINES-1:0]                            line_dirty;
    logic [TAG_BITS-1:0]                         tags [LINES];
    logic [nand_cpu_pkg::CACHE_BLOCK_SIZE-1:0]   blocks [LINES];

    logic [CNT_BITS-1:0] counter;
    logic                access;
    logic                match;
    logic                last_beat;
    logic                write_hit;

    nand_cpu_pkg::cache_state_t state;
    nand_cpu_pkg::cache_state_t next_state;

    assign offset    = address[OFFSET_BITS-1:0];
    assign index     = address[INDEX_BITS+OFFSET_BITS-1 -: INDEX_BITS];
    assign tag       = address[15 -: TAG_BITS];

    assign access    = valid & mem_access;
    assign match     = line_valid[index] & (tags[index] == tag);
    assign last_beat = (counter == CNT_BITS'(nand_cpu_pkg::BEATS - 1));
    assign write_hit = hit & (mem_op == nand_cpu_pkg::MEM_WRITE);

    assign rdata     = blocks[index][offset * WORD +: WORD];
    assign w_data    = blocks[index][counter * TRANS +: TRANS];

    // ----------------------------------------
    // Next state and memory request
    // ----------------------------------------
    always_comb begin
        next_state    = state;
        hit           = 1'b0;
        miss          = access;
        req           = nand_cpu_pkg::REQ_NONE;
        block_address = {tag, index};
        case (state)
            nand_cpu_pkg::READY: begin
                hit  = access & match;
                miss = access & ~match;
                if (miss) begin
                    next_state = line_dirty[index] ? nand_cpu_pkg::REQUEST_WRITE
                                                   : nand_cpu_pkg::REQUEST_READ;
                end
            end
            nand_cpu_pkg::REQUEST_WRITE: begin
                // The victim goes back to the block it came from
                req           = nand_cpu_pkg::REQ_WRITE;
                block_address = {tags[index], index};
                if (ack) begin
                    next_state = nand_cpu_pkg::WRITING;
                end
            end
            nand_cpu_pkg::WRITING: begin
                block_address = {tags[index], index};
                if (last_beat) begin
                    next_state = nand_cpu_pkg::REQUEST_READ;
                end
            end
            nand_cpu_pkg::REQUEST_READ: begin
                req = nand_cpu_pkg::REQ_READ;
                if (ack) begin
                    next_state = nand_cpu_pkg::READING;
                end
            end
            nand_cpu_pkg::READING: begin
                if (last_beat) begin
                    next_state = nand_cpu_pkg::READY;
                end
            end
            default: begin
                next_state = nand_cpu_pkg::READY;
            end
        endcase
    end

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state      <= nand_cpu_pkg::READY;
            counter    <= '0;
            line_valid <= '0;
            line_dirty <= '0;
        end else begin
            state <= next_state;
            case (state)
                nand_cpu_pkg::READY: begin
                    if (write_hit) begin
                        line_dirty[index] <= 1'b1;
                    end
                end
                nand_cpu_pkg::REQUEST_WRITE, nand_cpu_pkg::REQUEST_READ: begin
                    counter <= '0;
                end
                nand_cpu_pkg::WRITING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_dirty[index] <= 1'b0;
                    end
                end
                nand_cpu_pkg::READING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_valid[index] <= 1'b1;
                    end
                end
                default: begin
                    counter <= '0;
                end
            endcase
        end
    end

    // Line data and tags
    always_ff @(posedge clk) begin
        if (write_hit) begin
            blocks[index][offset * WORD +: WORD] <= data;
        end
        if (state == nand_cpu_pkg::READING) begin
            blocks[index][counter * TRANS +: TRANS] <= r_data;
            if (last_beat) begin
                tags[index] <= tag;
            end
        end
    end

endmodule

/* rtl/i_cache.sv */
`timescale 1ns/1ps

module i_cache #(
    parameter int INDEX_BITS = 5
) (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  logic                                       valid,
    input  logic [15:0]                                address,
    output logic                                       hit,
    output logic                                       miss,
    output logic [15:0]                                data,
    output nand_cpu_pkg::cache_request_t               req,
    output logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   block_address,
    input  logic                                       ack,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    r_data
);

    localparam int LINES       = 2 ** INDEX_BITS;
    localparam int OFFSET_BITS = nand_cpu_pkg::OFFSET_BITS;
    localparam int TAG_BITS    = 16 - INDEX_BITS - OFFSET_BITS;
    localparam int CNT_BITS    = $clog2(nand_cpu_pkg::BEATS);
    localparam int WORD        = nand_cpu_pkg::DATA_SIZE;
    localparam int TRANS       = nand_cpu_pkg::MEM_TRANS_SIZE;

    logic [OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]    tag;

    logic [LINES-1:0]                            line_valid;
    logic [TAG_BITS-1:0]                         tags [LINES];
    logic [nand_cpu_pkg::CACHE_BLOCK_SIZE-1:0]   blocks [LINES];

    logic [CNT_BITS-1:0] counter;
    logic                match;
    logic                last_beat;

    nand_cpu_pkg::cache_state_t state;

    assign offset        = address[OFFSET_BITS-1:0];
    assign index         = address[INDEX_BITS+OFFSET_BITS-1 -: INDEX_BITS];
    assign tag           = address[15 -: TAG_BITS];
    assign match         = line_valid[index] & (tags[index] == tag);
    assign last_beat     = (counter == CNT_BITS'(nand_cpu_pkg::BEATS - 1));

    assign hit           = valid & (state == nand_cpu_pkg::READY) & match;
    assign miss          = valid & ~hit;
    assign data          = blocks[index][offset * WORD +: WORD];
    assign block_address = {tag, index};
    assign req           = (state == nand_cpu_pkg::REQUEST_READ) ? nand_cpu_pkg::REQ_READ
                                                                 : nand_cpu_pkg::REQ_NONE;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state      <= nand_cpu_pkg::READY;
            counter    <= '0;
            line_valid <= '0;
        end else begin
            case (state)
                nand_cpu_pkg::READY: begin
                    if (miss) begin
                        state <= nand_cpu_pkg::REQUEST_READ;
                    end
                end
                nand_cpu_pkg::REQUEST_READ: begin
                    counter <= '0;
                    if (ack) begin
                        state <= nand_cpu_pkg::READING;
                    end
                end
                nand_cpu_pkg::READING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_valid[index] <= 1'b1;
                        state             <= nand_cpu_pkg::READY;
                    end
                end
                default: begin
                    state <= nand_cpu_pkg::READY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == nand_cpu_pkg::READING) begin
            blocks[index][counter * TRANS +: TRANS] <= r_data;
            if (last_beat) begin
                tags[index] <= tag;
            end
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  nand_cpu_pkg::cache_request_t               d_req,
    input  logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   d_block_address,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    d_w_data,
    output logic                                       d_ack,
    output logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    d_r_data,
    input  nand_cpu_pkg::cache_request_t               i_req,
    input  logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   i_block_address,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    i_w_data,
    output logic                                       i_ack,
    output logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    i_r_data,
    output nand_cpu_pkg::cache_request_t               req,
    output logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   block_address,
    output logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    w_data,
    input  logic                                       ack,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    r_data,
    input  logic                                       last
);

    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_D,
        GRANT_I
    } grant_t;

    grant_t grant;
    logic   sel_d;
    logic   sel_i;

    // While idle the choice is made on the fly so memory sees the request at once
    assign sel_d = (grant == GRANT_D) |
                   ((grant == GRANT_IDLE) & (d_req != nand_cpu_pkg::REQ_NONE));
    assign sel_i = (grant == GRANT_I) |
                   ((grant == GRANT_IDLE) & (d_req == nand_cpu_pkg::REQ_NONE) &
                    (i_req != nand_cpu_pkg::REQ_NONE));

    assign req           = sel_d ? d_req : (sel_i ? i_req : nand_cpu_pkg::REQ_NONE);
    assign block_address = sel_d ? d_block_address : i_block_address;
    assign w_data        = sel_d ? d_w_data : i_w_data;

    assign d_ack    = sel_d & ack;
    assign i_ack    = sel_i & ack;
    assign d_r_data = sel_d ? r_data : '0;
    assign i_r_data = sel_i ? r_data : '0;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            grant <= GRANT_IDLE;
        end else if (grant == GRANT_IDLE) begin
            if (sel_d) begin
                grant <= GRANT_D;
            end else if (sel_i) begin
                grant <= GRANT_I;
            end
        end else if (last) begin
            grant <= GRANT_IDLE;
        end
    end

endmodule

/* rtl/main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  nand_cpu_pkg::cache_request_t               req,
    input  logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   block_address,
    input  logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    w_data,
    output logic                                       ack,
    output logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    r_data,
    output logic                                       last
);

    localparam int BLOCKS   = 2 ** nand_cpu_pkg::BLOCK_ADDR_BITS;
    localparam int WORDS    = nand_cpu_pkg::CACHE_BLOCK_SIZE / nand_cpu_pkg::DATA_SIZE;
    localparam int WORD     = nand_cpu_pkg::DATA_SIZE;
    localparam int TRANS    = nand_cpu_pkg::MEM_TRANS_SIZE;
    localparam int LAT_BITS = $clog2(MEM_LATENCY + 1);
    localparam int CNT_BITS = $clog2(nand_cpu_pkg::BEATS);

    typedef enum logic [1:0] {
        M_IDLE,
        M_WAIT,
        M_BEAT
    } mem_state_t;

    logic [nand_cpu_pkg::CACHE_BLOCK_SIZE-1:0] mem [BLOCKS];

    mem_state_t                                 state;
    logic [LAT_BITS-1:0]                        lat_cnt;
    logic [CNT_BITS-1:0]                        beat_cnt;
    logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   blk;
    logic                                       is_write;

    // Word address a holds a XOR 16'hA5C3
    initial begin
        for (int b = 0; b < BLOCKS; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                mem[b][w * WORD +: WORD] = WORD'(b * WORDS + w) ^ 16'hA5C3;
            end
        end
    end

    assign ack    = (state == M_WAIT) & (lat_cnt == LAT_BITS'(MEM_LATENCY));
    assign last   = (state == M_BEAT) & (beat_cnt == CNT_BITS'(nand_cpu_pkg::BEATS - 1));
    assign r_data = mem[blk][beat_cnt * TRANS +: TRANS];

    // ----------------------------------------
    // Latency then beat sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state    <= M_IDLE;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (req != nand_cpu_pkg::REQ_NONE) begin
                        state   <= M_WAIT;
                        lat_cnt <= LAT_BITS'(1);
                    end
                end
                M_WAIT: begin
                    if (ack) begin
                        state    <= M_BEAT;
                        beat_cnt <= '0;
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                M_BEAT: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last) begin
                        state <= M_IDLE;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

    always @(posedge clk) begin
        if (state == M_IDLE && req != nand_cpu_pkg::REQ_NONE) begin
            blk      <= block_address;
            is_write <= (req == nand_cpu_pkg::REQ_WRITE);
        end
        if (state == M_BEAT && is_write) begin
            mem[blk][beat_cnt * TRANS +: TRANS] <= w_data;
        end
    end

endmodule

/* rtl/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int D_INDEX_BITS = 6,
    parameter int I_INDEX_BITS = 5,
    parameter int MEM_LATENCY  = 3
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  d_valid,
    input  logic                  d_mem_access,
    input  logic [15:0]           d_address,
    input  nand_cpu_pkg::mem_op_t d_mem_op,
    input  logic [15:0]           d_data,
    output logic                  d_hit,
    output logic                  d_miss,
    output logic [15:0]           d_rdata,
    input  logic                  i_valid,
    input  logic [15:0]           i_address,
    output logic                  i_hit,
    output logic                  i_miss,
    output logic [15:0]           i_data
);

    // ----------------------------------------
    // Cache to arbiter and arbiter to memory
    // ----------------------------------------
    nand_cpu_pkg::cache_request_t               d_req;
    logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   d_block_address;
    logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    d_w_data;
    logic                                       d_ack;
    logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    d_r_data;

    nand_cpu_pkg::cache_request_t               i_req;
    logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   i_block_address;
    logic                                       i_ack;
    logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    i_r_data;

    nand_cpu_pkg::cache_request_t               m_req;
    logic [nand_cpu_pkg::BLOCK_ADDR_BITS-1:0]   m_block_address;
    logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    m_w_data;
    logic                                       m_ack;
    logic [nand_cpu_pkg::MEM_TRANS_SIZE-1:0]    m_r_data;
    logic                                       m_last;

    d_cache #(.INDEX_BITS(D_INDEX_BITS)) u_d_cache (
        .clk(clk), .n_rst(n_rst),
        .valid(d_valid), .mem_access(d_mem_access), .address(d_address),
        .mem_op(d_mem_op), .data(d_data),
        .hit(d_hit), .miss(d_miss), .rdata(d_rdata),
        .req(d_req), .block_address(d_block_address), .w_data(d_w_data),
        .ack(d_ack), .r_data(d_r_data)
    );

    i_cache #(.INDEX_BITS(I_INDEX_BITS)) u_i_cache (
        .clk(clk), .n_rst(n_rst),
        .valid(i_valid), .address(i_address),
        .hit(i_hit), .miss(i_miss), .data(i_data),
        .req(i_req), .block_address(i_block_address),
        .ack(i_ack), .r_data(i_r_data)
    );

    // The instruction cache never writes back, so its write beat is held at zero
    mem_arbiter u_mem_arbiter (
        .clk(clk), .n_rst(n_rst),
        .d_req(d_req), .d_block_address(d_block_address), .d_w_data(d_w_data),
        .d_ack(d_ack), .d_r_data(d_r_data),
        .i_req(i_req), .i_block_address(i_block_address), .i_w_data('0),
        .i_ack(i_ack), .i_r_data(i_r_data),
        .req(m_req), .block_address(m_block_address), .w_data(m_w_data),
        .ack(m_ack), .r_data(m_r_data), .last(m_last)
    );

    main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_main_memory (
        .clk(clk), .n_rst(n_rst),
        .req(m_req), .block_address(m_block_address), .w_data(m_w_data),
        .ack(m_ack), .r_data(m_r_data), .last(m_last)
    );

endmodule

/* test/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int MEM_LATENCY = 3;
    localparam int CLK_PERIOD  = 8;
    localparam int MISS_CYCLES = MEM_LATENCY + 1 + nand_cpu_pkg::BEATS + 2;
    // Write-back, refill and one transfer of the other cache
    localparam int DIRTY_BOUND = 3 * MISS_CYCLES;
    localparam int N_RAND_D    = 48;
    localparam int N_RAND_I    = 16;
    localparam int N_ACCESSES  = 13 + N_RAND_D + N_RAND_I;

    localparam logic [1:0] KIND_ANY  = 2'd0;
    localparam logic [1:0] KIND_HIT  = 2'd1;
    localparam logic [1:0] KIND_MISS = 2'd2;

    logic                  clk;
    logic                  n_rst;
    logic                  d_valid;
    logic                  d_mem_access;
    logic [15:0]           d_address;
    nand_cpu_pkg::mem_op_t d_mem_op;
    logic [15:0]           d_data;
    logic                  d_hit;
    logic                  d_miss;
    logic [15:0]           d_rdata;
    logic                  i_valid;
    logic [15:0]           i_address;
    logic                  i_hit;
    logic                  i_miss;
    logic [15:0]           i_data;

    logic [15:0] shadow [65536];
    logic [15:0] d_expected;
    logic [15:0] i_expected;
    logic        d_hit_seen;
    logic        i_hit_seen;
    logic [1:0]  d_kind;
    logic [1:0]  i_kind;
    logic        d_first;
    logic        i_first;
    integer      seed;

    mem_subsystem #(.D_INDEX_BITS(6), .I_INDEX_BITS(5), .MEM_LATENCY(MEM_LATENCY)) i_dut (
        .clk(clk), .n_rst(n_rst),
        .d_valid(d_valid), .d_mem_access(d_mem_access), .d_address(d_address),
        .d_mem_op(d_mem_op), .d_data(d_data),
        .d_hit(d_hit), .d_miss(d_miss), .d_rdata(d_rdata),
        .i_valid(i_valid), .i_address(i_address),
        .i_hit(i_hit), .i_miss(i_miss), .i_data(i_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Word address a starts out as a XOR 16'hA5C3
    initial begin
        for (int a = 0; a < 65536; a++) begin
            shadow[a] = 16'(a) ^ 16'hA5C3;
        end
    end

    assign d_expected = shadow[d_address];
    assign i_expected = shadow[i_address];

    always @(posedge clk) begin
        d_hit_seen <= d_hit;
        i_hit_seen <= i_hit;
        if (n_rst && d_hit && d_mem_op == nand_cpu_pkg::MEM_WRITE) begin
            shadow[d_address] <= d_data;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    d_quiet: assert property (@(posedge clk) disable iff (!n_rst)
        !d_valid |-> !d_hit && !d_miss)
    else report_failure($sformatf("[ERROR] d_hit/d_miss expected 0/0 actual %h/%h",
                                  $sampled(d_hit), $sampled(d_miss)));

    i_quiet: assert property (@(posedge clk) disable iff (!n_rst)
        !i_valid |-> !i_hit && !i_miss)
    else report_failure($sformatf("[ERROR] i_hit/i_miss expected 0/0 actual %h/%h",
                                  $sampled(i_hit), $sampled(i_miss)));

    d_read_data: assert property (@(posedge clk) disable iff (!n_rst)
        d_hit && d_mem_op == nand_cpu_pkg::MEM_READ |-> d_rdata == d_expected)
    else report_failure($sformatf("[ERROR] d_rdata at %h expected %h actual %h",
                                  $sampled(d_address), $sampled(d_expected),
                                  $sampled(d_rdata)));

    i_fetch_data: assert property (@(posedge clk) disable iff (!n_rst)
        i_hit |-> i_data == i_expected)
    else report_failure($sformatf("[ERROR] i_data at %h expected %h actual %h",
                                  $sampled(i_address), $sampled(i_expected),
                                  $sampled(i_data)));

    d_first_hit: assert property (@(posedge clk) disable iff (!n_rst)
        d_first && d_kind == KIND_HIT |-> d_hit)
    else report_failure("A data access to a resident line did not hit at once");

    d_first_miss: assert property (@(posedge clk) disable iff (!n_rst)
        d_first && d_kind == KIND_MISS |-> d_miss)
    else report_failure("A data access to a line that is not resident did not miss");

    i_first_hit: assert property (@(posedge clk) disable iff (!n_rst)
        i_first && i_kind == KIND_HIT |-> i_hit)
    else report_failure("A fetch from a resident line did not hit at once");

    i_first_miss: assert property (@(posedge clk) disable iff (!n_rst)
        i_first && i_kind == KIND_MISS |-> i_miss)
    else report_failure("A fetch from a line that is not resident did not miss");

    d_resolves: assert property (@(posedge clk) disable iff (!n_rst)
        d_miss |-> ##[1:DIRTY_BOUND] d_hit)
    else report_failure("A data cache miss was not resolved in time");

    i_resolves: assert property (@(posedge clk) disable iff (!n_rst)
        i_miss |-> ##[1:DIRTY_BOUND] i_hit)
    else report_failure("An instruction cache miss was not resolved in time");

    // ----------------------------------------
    // Access tasks
    // ----------------------------------------
    task automatic d_access(input logic [15:0] addr, input logic write,
                            input logic [15:0] wdata, input logic [1:0] kind);
        int cycles;
        cycles = 0;
        @(negedge clk);
        d_valid      = 1'b1;
        d_mem_access = 1'b1;
        d_address    = addr;
        d_data       = wdata;
        if (write) begin
            d_mem_op = nand_cpu_pkg::MEM_WRITE;
        end else begin
            d_mem_op = nand_cpu_pkg::MEM_READ;
        end
        d_kind  = kind;
        d_first = 1'b1;
        @(negedge clk);
        d_first = 1'b0;
        while (!d_hit_seen) begin
            if (cycles == DIRTY_BOUND) begin
                report_failure($sformatf("Timeout: data access to %h never hit", addr));
            end
            cycles++;
            @(negedge clk);
        end
        d_valid      = 1'b0;
        d_mem_access = 1'b0;
    endtask

    task automatic i_fetch(input logic [15:0] addr, input logic [1:0] kind);
        int cycles;
        cycles = 0;
        @(negedge clk);
        i_valid   = 1'b1;
        i_address = addr;
        i_kind    = kind;
        i_first   = 1'b1;
        @(negedge clk);
        i_first = 1'b0;
        while (!i_hit_seen) begin
            if (cycles == DIRTY_BOUND) begin
                report_failure($sformatf("Timeout: fetch from %h never hit", addr));
            end
            cycles++;
            @(negedge clk);
        end
        i_valid = 1'b0;
    endtask

    initial begin
        #((N_ACCESSES * 2 * DIRTY_BOUND + 20) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        seed         = 32'h733f;
        n_rst        = 1'b0;
        d_valid      = 1'b0;
        d_mem_access = 1'b0;
        d_address    = '0;
        d_mem_op     = nand_cpu_pkg::MEM_READ;
        d_data       = '0;
        i_valid      = 1'b0;
        i_address    = '0;
        d_kind       = KIND_ANY;
        i_kind       = KIND_ANY;
        d_first      = 1'b0;
        i_first      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        repeat (4) @(negedge clk);

        // Cold accesses, then a write hit and its read back
        d_access(16'h0123, 1'b0, 16'h0000, KIND_MISS);
        i_fetch(16'h8000, KIND_MISS);
        d_access(16'h0123, 1'b1, 16'hBEEF, KIND_HIT);
        d_access(16'h0123, 1'b0, 16'h0000, KIND_HIT);

        // Same index, different tag, so the dirty line goes back to memory
        d_access(16'h2045, 1'b1, 16'h5A17, KIND_MISS);
        d_access(16'h3045, 1'b0, 16'h0000, KIND_MISS);
        d_access(16'h2045, 1'b0, 16'h0000, KIND_MISS);

        i_fetch(16'h2045, KIND_MISS);
        i_fetch(16'h8001, KIND_HIT);
        i_fetch(16'h8003, KIND_HIT);
        i_fetch(16'h8004, KIND_MISS);

        // Both caches miss on the same edge
        fork
            d_access(16'h0400, 1'b0, 16'h0000, KIND_MISS);
            i_fetch(16'h8400, KIND_MISS);
        join

        for (int n = 0; n < N_RAND_D; n++) begin
            d_access(16'h1000 | (16'($random(seed)) & 16'h0F0F), 1'($random(seed)),
                     16'($random(seed)), KIND_ANY);
        end
        for (int n = 0; n < N_RAND_I; n++) begin
            i_fetch(16'h8000 | (16'($random(seed)) & 16'h00FF), KIND_ANY);
        end

        repeat (4) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* build.f */
rtl/nand_cpu_pkg.sv
rtl/d_cache.sv
rtl/i_cache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/mem_subsystem.sv
test/tb_mem_subsystem.sv
